// ==== Bender.yml ====
package:
  name: timing

sources:
  - verilog/timing_pkg.sv
  - verilog/phase_gen.sv
  - verilog/digit_timer.sv
  - verilog/prog_phase_seq.sv
  - verilog/ext_exchange.sv
  - verilog/timing_top.sv
  - target: test
    files:
      - testbench/timing_tb.sv

// ==== sim.f ====
verilog/timing_pkg.sv
verilog/phase_gen.sv
verilog/digit_timer.sv
verilog/prog_phase_seq.sv
verilog/ext_exchange.sv
verilog/timing_top.sv
testbench/timing_tb.sv

// ==== testbench/timing_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module timing_tb;

    localparam int num_digits = 4;      // short words, so a slow device stalls C
    localparam int wait_limit = 1000;   // clocks

    logic                    sim_clk;
    logic                    rst;
    logic                    run;
    logic                    ext_ack;
    timing_pkg::subphase_t   sub;
    timing_pkg::digit_idx_t  digit;
    logic                    ad;
    logic                    word_end;
    timing_pkg::prog_phase_e phase;
    logic                    ext_req;

    int                      ref_pos;       // 0 = v1 .. 5 = v4
    int                      ref_digit;
    logic                    ref_ad;
    logic                    ref_word_end;
    timing_pkg::prog_phase_e ref_phase;
    int                      ref_xs;        // idle, req, ack low wait, done
    logic                    ref_req;
    logic [5:0]              exp_sub;
    logic                    rst_q = 1'b0;
    logic                    req_q;
    timing_pkg::prog_phase_e phase_q;
    int                      req_pulses;    // req rises in this visit to C

    string cur_test = "reset";
    int    errors = 0;
    int    test_start;
    int    tests_passed = 0;
    int    tests_failed = 0;
    logic  timed_out = 1'b0;

    timing_top #(
        .num_digits (num_digits)
    ) u_timing_top (
        .sim_clk  (sim_clk),
        .rst      (rst),
        .run      (run),
        .ext_ack  (ext_ack),
        .sub      (sub),
        .digit    (digit),
        .ad       (ad),
        .word_end (word_end),
        .phase    (phase),
        .ext_req  (ext_req)
    );

    initial begin
        sim_clk = 1'b0;
        forever #10 sim_clk = ~sim_clk;
    end

    // ========================================================================
    // reference counters
    // ========================================================================

    assign exp_sub      = 6'b100000 >> ref_pos;
    assign ref_word_end = (ref_pos == 5) && ref_ad && (ref_digit == num_digits - 1);

    always @(posedge sim_clk) begin
        rst_q   <= rst;
        req_q   <= ext_req;
        phase_q <= phase;
        if (rst) begin
            ref_pos    <= 0;
            ref_digit  <= 0;
            ref_ad     <= 1'b0;
            ref_phase  <= timing_pkg::ph_a;
            ref_xs     <= 0;
            ref_req    <= 1'b0;
            req_pulses <= 0;
        end else begin
            ref_pos <= (ref_pos + 1) % 6;
            if (ref_pos == 5) begin
                ref_digit <= (ref_digit + 1) % num_digits;
                if (ref_digit == num_digits - 1) begin
                    ref_ad <= ~ref_ad;
                end
            end
            if (ref_word_end && run) begin
                case (ref_phase)
                    timing_pkg::ph_a: ref_phase <= timing_pkg::ph_b;
                    timing_pkg::ph_b: ref_phase <= timing_pkg::ph_c;
                    default: begin
                        if (ref_xs == 3) ref_phase <= timing_pkg::ph_a;
                    end
                endcase
            end
            ref_req <= 1'b0;
            case (ref_xs)
                0: begin
                    if (ref_word_end && ref_phase == timing_pkg::ph_c) begin
                        ref_xs  <= 1;
                        ref_req <= 1'b1;    // one clock after word_end
                    end
                end
                1: begin
                    if (ext_ack) ref_xs <= 2;
                    else ref_req <= 1'b1;
                end
                2: begin
                    if (!ext_ack) ref_xs <= 3;
                end
                default: begin
                    if (ref_phase != timing_pkg::ph_c) ref_xs <= 0;
                end
            endcase
            if (phase != timing_pkg::ph_c) req_pulses <= 0;
            else if (ext_req && !req_q) req_pulses <= req_pulses + 1;
        end
    end

    task automatic report_mismatch(input string what, input int expected, input int actual);
        errors++;
        $display("Fail %s: %s expected %0h actual %0h", cur_test, what, expected, actual);
    endtask

    task automatic report_rule(input string msg);
        errors++;
        $display("error in %s: %s", cur_test, msg);
    endtask

    task automatic report_timeout(input string what);
        errors++;
        timed_out = 1'b1;
        $display("timeout in %s: no %s within %0d clocks", cur_test, what, wait_limit);
    endtask

    // ========================================================================
    // assertions
    // ========================================================================

    a_sub: assert property (@(posedge sim_clk) disable iff (rst) sub == exp_sub)
        else report_mismatch("sub", $sampled(exp_sub), $sampled(sub));
    a_digit: assert property (@(posedge sim_clk) disable iff (rst) digit == ref_digit)
        else report_mismatch("digit", $sampled(ref_digit), $sampled(digit));
    a_ad: assert property (@(posedge sim_clk) disable iff (rst) ad == ref_ad)
        else report_mismatch("ad", $sampled(ref_ad), $sampled(ad));
    a_word_end: assert property (@(posedge sim_clk) disable iff (rst) word_end == ref_word_end)
        else report_mismatch("word_end", $sampled(ref_word_end), $sampled(word_end));
    a_phase: assert property (@(posedge sim_clk) disable iff (rst) phase == ref_phase)
        else report_mismatch("phase", $sampled(ref_phase), $sampled(phase));
    a_req: assert property (@(posedge sim_clk) disable iff (rst) ext_req == ref_req)
        else report_mismatch("ext_req", $sampled(ref_req), $sampled(ext_req));

    a_reset_values: assert property (@(posedge sim_clk)
        rst_q |-> (sub == 6'b100000) && (digit == 0) && !ad
                  && (phase == timing_pkg::ph_a) && !ext_req
    ) else report_rule("outputs not at reset values one clock after reset");

    // four-phase protocol seen from the device side
    a_req_rise: assert property (@(posedge sim_clk) disable iff (rst)
        $rose(ext_req) |-> $past(word_end) && (phase == timing_pkg::ph_c) && !$past(ext_ack)
    ) else report_rule("req rose without word_end in phase C with ack low");
    a_req_fall: assert property (@(posedge sim_clk) disable iff (rst)
        $fell(ext_req) |-> $past(ext_ack)
    ) else report_rule("req fell before ack was high");
    a_req_low_while_ack: assert property (@(posedge sim_clk) disable iff (rst)
        ext_ack && !ext_req |=> !ext_req
    ) else report_rule("req rose again while ack still high");

    a_hold_c: assert property (@(posedge sim_clk) disable iff (rst)
        word_end && (phase == timing_pkg::ph_c) && (ext_req || ext_ack)
            |=> phase == timing_pkg::ph_c
    ) else report_rule("phase left C during an unfinished exchange");
    a_one_req: assert property (@(posedge sim_clk) disable iff (rst)
        (phase_q == timing_pkg::ph_c) && (phase == timing_pkg::ph_a) && !rst_q
            |-> req_pulses == 1
    ) else report_mismatch("req pulses per C visit", 1, $sampled(req_pulses));

    // ========================================================================
    // ack responder sampling at +1 ns and driving at +2 ns
    // ========================================================================

    initial begin
        int   resp_state;
        int   delay;
        logic ack_next;
        resp_state = 0;
        delay      = 0;
        ack_next   = 1'b0;
        ext_ack    = 1'b0;
        forever begin
            @(posedge sim_clk);
            #1;
            if (rst) begin
                resp_state = 0;
                ack_next   = 1'b0;
            end else if (resp_state == 0 && ext_req) begin
                delay      = $urandom_range(40, 1);
                resp_state = 1;
            end else if (resp_state == 1) begin
                delay--;
                if (delay == 0) begin
                    ack_next   = 1'b1;
                    resp_state = 2;
                end
            end else if (resp_state == 2 && !ext_req) begin
                delay      = $urandom_range(40, 1);    // ack lingers after req drops
                resp_state = 3;
            end else if (resp_state == 3) begin
                delay--;
                if (delay == 0) begin
                    ack_next   = 1'b0;
                    resp_state = 0;
                end
            end
            #1;
            ext_ack = ack_next;
        end
    end

    // ========================================================================
    // waits and test bookkeeping
    // ========================================================================

    task automatic wait_word_ends(input int n);
        int seen;
        int cycles;
        seen   = 0;
        cycles = 0;
        while (seen < n && !timed_out) begin
            @(posedge sim_clk);
            #2;
            if (word_end) seen++;
            cycles++;
            if (cycles > wait_limit) report_timeout("word_end");
        end
    endtask

    task automatic wait_phase(input timing_pkg::prog_phase_e p);
        int cycles;
        cycles = 0;
        while (phase != p && !timed_out) begin
            @(posedge sim_clk);
            #2;
            cycles++;
            if (cycles > wait_limit) report_timeout($sformatf("phase %s", p.name()));
        end
    endtask

    task automatic wait_req(input logic level);
        int cycles;
        cycles = 0;
        while (ext_req != level && !timed_out) begin
            @(posedge sim_clk);
            #2;
            cycles++;
            if (cycles > wait_limit) report_timeout($sformatf("ext_req at %b", level));
        end
    endtask

    // run low across n word ends, then high again
    task automatic hold_run_low(input int n);
        run = 1'b0;
        wait_word_ends(n);
        @(posedge sim_clk);
        #2;
        run = 1'b1;
    endtask

    task automatic begin_test(input string name);
        cur_test   = name;
        test_start = errors;
    endtask

    task automatic end_test();
        if (errors == test_start) begin
            tests_passed++;
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, errors - test_start);
        end
    endtask

    // ========================================================================
    // stimulus
    // ========================================================================

    initial begin
        void'($urandom(62));
        rst = 1'b1;
        run = 1'b0;
        repeat (5) @(posedge sim_clk);
        #2;
        rst = 1'b0;

        begin_test("subphase order");
        repeat (18) @(posedge sim_clk);
        #2;
        end_test();

        begin_test("digit timing");
        wait_word_ends(2);
        end_test();

        begin_test("program sequencing");
        hold_run_low($urandom_range(3, 1));
        wait_phase(timing_pkg::ph_b);
        hold_run_low($urandom_range(2, 1));    // B must hold here
        wait_phase(timing_pkg::ph_c);
        end_test();

        begin_test("exchange handshake");
        wait_req(1'b1);
        wait_req(1'b0);
        wait_phase(timing_pkg::ph_a);
        end_test();

        begin_test("back-pressure");
        repeat (8) begin
            wait_phase(timing_pkg::ph_c);
            wait_phase(timing_pkg::ph_a);
        end
        end_test();

        begin_test("reset mid-run");
        wait_phase(timing_pkg::ph_c);
        wait_req(1'b1);
        rst = 1'b1;
        repeat (3) @(posedge sim_clk);
        #2;
        rst = 1'b0;
        wait_word_ends(3);
        end_test();

        $display("tests: %0d ok, %0d failed, %0d errors", tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/digit_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

module digit_timer #(
    parameter int num_digits = 7
) (
    input  logic                   sim_clk,
    input  logic                   rst,
    input  timing_pkg::subphase_t  sub,
    output timing_pkg::digit_idx_t digit,
    output logic                   ad,
    output logic                   word_end
);

    localparam timing_pkg::digit_idx_t last_digit =
        timing_pkg::digit_idx_t'(num_digits - 1);

    logic at_last;      // digit sits on the final position

    assign at_last = (digit == last_digit);

    // ========================================================================
    // digit counter and alternate-digit bit
    // ========================================================================

    // G1..G7 and AD step together at the end of each bit time
    always_ff @(posedge sim_clk) begin
        if (rst) begin
            digit <= '0;
            ad    <= 1'b0;
        end else if (sub.v4) begin
            if (at_last) begin
                digit <= '0;
                ad    <= ~ad;   // second half of the word begins / ends
            end else begin
                digit <= digit + timing_pkg::digit_idx_t'(1);
            end
        end
    end

    // last bit of the word is last digit in the ad half
    assign word_end = sub.v4 & ad & at_last;

    // ========================================================================
    // checks
    // ========================================================================

    a_num_digits_range: assert property (
        @(posedge sim_clk)
        (num_digits >= 2) && (num_digits <= timing_pkg::max_digits)
    ) else $error("digit_timer: num_digits %0d out of range", num_digits);

    a_digit_bound: assert property (
        @(posedge sim_clk) disable iff (rst)
        digit < num_digits
    ) else $error("digit_timer: digit %0d reached num_digits", digit);

endmodule

`default_nettype wire

// ==== verilog/ext_exchange.sv ====
`timescale 1ns/10ps
`default_nettype none

module ext_exchange (
    input  logic                    sim_clk,
    input  logic                    rst,
    input  logic                    word_end,
    input  timing_pkg::prog_phase_e phase,
    input  logic                    ext_ack,
    output logic                    ext_req,
    output logic                    xchg_done
);

    timing_pkg::xchg_state_e state;
    timing_pkg::xchg_state_e state_next;

    // ========================================================================
    // four-phase req/ack FSM
    // ========================================================================

    always_comb begin
        state_next = state;
        case (state)
            timing_pkg::xs_idle: begin
                if (word_end && (phase == timing_pkg::ph_c)) begin
                    state_next = timing_pkg::xs_req;
                end
            end
            timing_pkg::xs_req: begin
                if (ext_ack) state_next = timing_pkg::xs_wait_low;
            end
            timing_pkg::xs_wait_low: begin
                if (!ext_ack) state_next = timing_pkg::xs_done;
            end
            timing_pkg::xs_done: begin
                // one handshake per visit to C
                if (phase != timing_pkg::ph_c) state_next = timing_pkg::xs_idle;
            end
            default: state_next = timing_pkg::xs_idle;
        endcase
    end

    always_ff @(posedge sim_clk) begin
        if (rst) begin
            state   <= timing_pkg::xs_idle;
            ext_req <= 1'b0;
        end else begin
            state   <= state_next;
            ext_req <= (state_next == timing_pkg::xs_req);  // registered req
        end
    end

    assign xchg_done = (state == timing_pkg::xs_done);

    // ========================================================================
    // checks
    // ========================================================================

    a_req_falls_after_ack: assert property (
        @(posedge sim_clk) disable iff (rst)
        $fell(ext_req) |-> $past(ext_ack) || $past(rst)
    ) else $error("ext_exchange: req dropped before ack was seen");

    a_req_only_in_c: assert property (
        @(posedge sim_clk) disable iff (rst)
        ext_req |-> (phase == timing_pkg::ph_c)
    ) else $error("ext_exchange: req high outside phase C");

endmodule

`default_nettype wire

// ==== verilog/phase_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module phase_gen (
    input  logic                  sim_clk,
    input  logic                  rst,
    output timing_pkg::subphase_t sub
);

    // ========================================================================
    // six-stage one-hot ring
    // ========================================================================

    always_ff @(posedge sim_clk) begin
        if (rst) begin
            sub <= timing_pkg::subphase_t'{v1: 1'b1, default: 1'b0};
        end else begin
            sub.v1 <= sub.v4;   // wrap into the next bit time
            sub.w3 <= sub.v1;
            sub.x3 <= sub.w3;
            sub.y3 <= sub.x3;
            sub.z1 <= sub.y3;
            sub.v4 <= sub.z1;
        end
    end

    // ========================================================================
    // checks
    // ========================================================================

    // ring must never lose or duplicate its token
    a_sub_onehot: assert property (
        @(posedge sim_clk) disable iff (rst)
        $onehot(sub)
    ) else $error("phase_gen: sub-phases not one-hot (%b)", sub);

endmodule

`default_nettype wire

// ==== verilog/prog_phase_seq.sv ====
`timescale 1ns/10ps
`default_nettype none

module prog_phase_seq (
    input  logic                    sim_clk,
    input  logic                    rst,
    input  logic                    word_end,
    input  logic                    run,
    input  logic                    xchg_done,
    output timing_pkg::prog_phase_e phase
);

    timing_pkg::prog_phase_e phase_next;

    // ========================================================================
    // next phase, decided only at a word boundary
    // ========================================================================

    always_comb begin
        phase_next = phase;
        if (word_end && run) begin
            case (phase)
                timing_pkg::ph_a: begin
                    phase_next = timing_pkg::ph_b;
                end
                timing_pkg::ph_b: begin
                    phase_next = timing_pkg::ph_c;
                end
                timing_pkg::ph_c: begin
                    // stay in C while the outside device is busy
                    if (xchg_done) begin
                        phase_next = timing_pkg::ph_a;
                    end
                end
                default: begin
                    phase_next = timing_pkg::ph_a;  // recover from the unused code
                end
            endcase
        end
    end

    always_ff @(posedge sim_clk) begin
        if (rst) begin
            phase <= timing_pkg::ph_a;
        end else begin
            phase <= phase_next;
        end
    end

    // ========================================================================
    // checks
    // ========================================================================

    a_step_on_word_end: assert property (
        @(posedge sim_clk) disable iff (rst)
        !$stable(phase) |-> $past(word_end) || $past(rst)
    ) else $error("prog_phase_seq: phase changed without word_end");

endmodule

`default_nettype wire

// ==== verilog/timing_pkg.sv ====
`default_nettype none

package timing_pkg;

    // ========================================================================
    // sub-phases of one bit time
    // ========================================================================

    // one field high per clock rotating v1 -> v4
    typedef struct packed {
        logic v1;   // bit start
        logic w3;   // digit counter steering
        logic x3;
        logic y3;   // program phase steering
        logic z1;   // exchange steering
        logic v4;   // bit end, counters step here
    } subphase_t;

    // ========================================================================
    // digit timing
    // ========================================================================

    typedef logic [3:0] digit_idx_t;    // position within the word

    // upper bound for num_digits as given by digit_idx_t
    localparam int max_digits = 16;

    // ========================================================================
    // state machines
    // ========================================================================

    // program phase as the PAA / PBA / PCA flip-flops
    typedef enum logic [1:0] {
        ph_a,
        ph_b,
        ph_c
    } prog_phase_e;

    // external exchange from REXC and RECA..RECC
    typedef enum logic [1:0] {
        xs_idle,
        xs_req,         // req high, waiting for ack
        xs_wait_low,    // req dropped, waiting for ack to fall
        xs_done
    } xchg_state_e;

endpackage

`default_nettype wire

// ==== verilog/timing_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module timing_top #(
    parameter int num_digits = 7
) (
    input  logic                    sim_clk,
    input  logic                    rst,
    input  logic                    run,
    input  logic                    ext_ack,
    output timing_pkg::subphase_t   sub,
    output timing_pkg::digit_idx_t  digit,
    output logic                    ad,
    output logic                    word_end,
    output timing_pkg::prog_phase_e phase,
    output logic                    ext_req
);

    logic xchg_done;    // exchange back to sequencer

    phase_gen u_phase_gen (
        .sim_clk (sim_clk),
        .rst     (rst),
        .sub     (sub)
    );

    digit_timer #(
        .num_digits (num_digits)
    ) u_digit_timer (
        .sim_clk  (sim_clk),
        .rst      (rst),
        .sub      (sub),
        .digit    (digit),
        .ad       (ad),
        .word_end (word_end)
    );

    prog_phase_seq u_prog_phase_seq (
        .sim_clk   (sim_clk),
        .rst       (rst),
        .word_end  (word_end),
        .run       (run),
        .xchg_done (xchg_done),
        .phase     (phase)
    );

    ext_exchange u_ext_exchange (
        .sim_clk   (sim_clk),
        .rst       (rst),
        .word_end  (word_end),
        .phase     (phase),
        .ext_ack   (ext_ack),
        .ext_req   (ext_req),
        .xchg_done (xchg_done)
    );

endmodule

`default_nettype wire
